//--- verilog/intOpPkg.sv
`default_nettype none

package intOpPkg;

    localparam int XLen = 32;
    localparam int NumLanes = 3; // identical ALU lanes in the cluster

    typedef logic [XLen-1:0] Word_t;
    typedef logic [XLen-1:0] Imm_t;
    typedef logic [1:0] Lane_t;

    typedef enum logic [5:0] {
        OpAdd, OpSub, OpAnd, OpOr, OpXor,
        OpSll, OpSrl, OpSra, OpSlt, OpSltu,
        OpLui, OpAuipc,
        // bit-manipulation subset
        OpAndn, OpOrn, OpXnor,
        OpMin, OpMax, OpMinu, OpMaxu,
        OpSh1add, OpSh2add, OpSh3add,
        OpClz, OpCtz, OpCpop,
        OpRev8, OpOrcB, OpSextB, OpSextH,
        // control transfer
        OpBeq, OpBne, OpBlt, OpBge, OpBltu, OpBgeu,
        OpJal
    } IntOp_t;

endpackage

`default_nettype wire

//--- verilog/uopPkg.sv
`default_nettype none

package uopPkg;

    import intOpPkg::*;

    typedef logic [6:0] SqN_t;
    typedef logic [5:0] Tag_t;

    typedef struct packed {
        Word_t  srcA;
        Word_t  srcB;
        Imm_t   imm;
        Word_t  pc;
        IntOp_t opcode;
        SqN_t   sqN;
        Tag_t   tagDst;
        logic   compressed; // 16-bit encoding, next pc is pc+2
        logic   predTaken;  // direction the front end predicted
    } IntUop;

    typedef struct packed {
        Word_t result;
        Tag_t  tagDst;
        SqN_t  sqN;
        logic  mispredict;
        Word_t dstPc; // only meaningful with mispredict set
    } IntResult;

    // sequence numbers wrap, so age comes from the signed difference
    function automatic logic isYounger(SqN_t a, SqN_t b);
        SqN_t diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

endpackage

`default_nettype wire

//--- verilog/bitCount.sv
`timescale 1ns/1ps
`default_nettype none

module bitCount import intOpPkg::*; (
    input  Word_t      word,
    output logic [5:0] lzc,
    output logic [5:0] popCount
);

    always_comb begin
        lzc = 6'(XLen); // all zero word
        for (int i = 0; i < XLen; i++) begin
            if (word[i]) begin
                lzc = 6'(XLen - 1 - i); // highest set bit wins
            end
        end
    end

    always_comb begin
        popCount = '0;
        for (int i = 0; i < XLen; i++) begin
            popCount = popCount + 6'(word[i]);
        end
    end

endmodule

`default_nettype wire

//--- verilog/intAlu.sv
`timescale 1ns/1ps
`default_nettype none

module intAlu import intOpPkg::*; import uopPkg::*; (
    input  wire      clk,
    input  wire      rst,
    input  IntUop    laneUop,
    input  wire      laneValid,
    output logic     laneReady,
    input  wire      invalidate,
    input  SqN_t     invalidateSqN,
    output IntResult resOut,
    output logic     resValid,
    input  wire      resReady
);

    Word_t srcA;
    Word_t srcB;
    Imm_t imm;
    Word_t srcARev;
    Word_t countIn;
    Word_t pcNext;
    Word_t resC;
    Word_t branchDst;
    logic [5:0] lzc;
    logic [5:0] popCount;
    logic lessThan;
    logic lessThanU;
    logic isBranch;
    logic taken;
    logic mispredict;
    logic accept;
    logic killIn;
    logic killHeld;
    logic held;
    IntResult resReg;

    assign srcA = laneUop.srcA;
    assign srcB = laneUop.srcB;
    assign imm = laneUop.imm;

    always_comb begin
        for (int i = 0; i < XLen; i++) begin
            srcARev[i] = srcA[XLen-1-i];
        end
    end

    assign countIn = (laneUop.opcode == OpCtz) ? srcARev : srcA; // ctz is clz of the mirror

    bitCount i_bitCount (
        .word     (countIn),
        .lzc      (lzc),
        .popCount (popCount)
    );

    assign lessThan = $signed(srcA) < $signed(srcB);
    assign lessThanU = srcA < srcB;
    assign pcNext = laneUop.compressed ? laneUop.pc + 32'd2 : laneUop.pc + 32'd4;

    always_comb begin
        case (laneUop.opcode)
            OpAdd:    resC = srcA + srcB;
            OpSub:    resC = srcA - srcB;
            OpAnd:    resC = srcA & srcB;
            OpOr:     resC = srcA | srcB;
            OpXor:    resC = srcA ^ srcB;
            OpSll:    resC = srcA << srcB[4:0];
            OpSrl:    resC = srcA >> srcB[4:0];
            OpSra:    resC = $signed(srcA) >>> srcB[4:0];
            OpSlt:    resC = {{(XLen-1){1'b0}}, lessThan};
            OpSltu:   resC = {{(XLen-1){1'b0}}, lessThanU};
            OpLui:    resC = imm;
            OpAuipc:  resC = laneUop.pc + imm;
            OpAndn:   resC = srcA & ~srcB;
            OpOrn:    resC = srcA | ~srcB;
            OpXnor:   resC = srcA ^ ~srcB;
            OpMin:    resC = lessThan ? srcA : srcB;
            OpMax:    resC = lessThan ? srcB : srcA;
            OpMinu:   resC = lessThanU ? srcA : srcB;
            OpMaxu:   resC = lessThanU ? srcB : srcA;
            OpSh1add: resC = srcB + (srcA << 1);
            OpSh2add: resC = srcB + (srcA << 2);
            OpSh3add: resC = srcB + (srcA << 3);
            OpClz,
            OpCtz:    resC = {{(XLen-6){1'b0}}, lzc};
            OpCpop:   resC = {{(XLen-6){1'b0}}, popCount};
            OpRev8:   resC = {srcA[7:0], srcA[15:8], srcA[23:16], srcA[31:24]};
            OpOrcB:   resC = {{8{|srcA[31:24]}}, {8{|srcA[23:16]}},
                              {8{|srcA[15:8]}}, {8{|srcA[7:0]}}};
            OpSextB:  resC = {{24{srcA[7]}}, srcA[7:0]};
            OpSextH:  resC = {{16{srcA[15]}}, srcA[15:0]};
            OpJal:    resC = pcNext; // link value
            default:  resC = '0; // conditional branches write nothing useful
        endcase
    end

    always_comb begin
        isBranch = 1'b1;
        case (laneUop.opcode)
            OpBeq:   taken = srcA == srcB;
            OpBne:   taken = srcA != srcB;
            OpBlt:   taken = lessThan;
            OpBge:   taken = !lessThan;
            OpBltu:  taken = lessThanU;
            OpBgeu:  taken = !lessThanU;
            OpJal:   taken = 1'b1;
            default: begin
                taken = 1'b0;
                isBranch = 1'b0;
            end
        endcase
    end

    assign mispredict = isBranch && (taken != laneUop.predTaken);
    assign branchDst = taken ? laneUop.pc + {{19{imm[12]}}, imm[12:0]} : pcNext;

    assign killIn = invalidate && isYounger(laneUop.sqN, invalidateSqN);
    assign killHeld = invalidate && isYounger(resReg.sqN, invalidateSqN);

    assign resValid = held && !killHeld; // a killed result never reaches the arbiter
    assign resOut = resReg;
    assign laneReady = !resValid || resReady;
    assign accept = laneValid && laneReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            held <= 1'b0;
        end else if (accept) begin
            held <= !killIn;
        end else if (resReady || killHeld) begin
            held <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            resReg.result <= resC;
            resReg.tagDst <= laneUop.tagDst;
            resReg.sqN <= laneUop.sqN;
            resReg.mispredict <= mispredict;
            resReg.dstPc <= branchDst;
        end
    end

    // a stalled result must look the same to the arbiter on the next cycle
    assert property (@(posedge clk) disable iff (rst)
        resValid && !resReady |=> $stable(resOut));

    // a refused result stays in the register until it is drained or killed
    assert property (@(posedge clk) disable iff (rst)
        resValid && !resReady |=> held);

endmodule

`default_nettype wire

//--- verilog/issueDispatch.sv
`timescale 1ns/1ps
`default_nettype none

module issueDispatch import intOpPkg::*; import uopPkg::*; (
    input  wire                  clk,
    input  wire                  rst,
    input  IntUop                inUop,
    input  wire                  inValid,
    output logic                 inReady,
    output IntUop                laneUop [NumLanes],
    output logic [NumLanes-1:0]  laneValid,
    input  wire  [NumLanes-1:0]  laneReady
);

    Lane_t ptr;

    always_comb begin
        laneValid = '0;
        laneValid[ptr] = inValid; // only the pointed-to lane sees the micro-op
        for (int i = 0; i < NumLanes; i++) begin
            laneUop[i] = inUop;
        end
    end

    assign inReady = laneReady[ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (inValid && inReady) begin
            ptr <= (ptr == Lane_t'(NumLanes - 1)) ? '0 : ptr + 2'd1;
        end
    end

    // a valid micro-op always lands on exactly one existing lane
    assert property (@(posedge clk) disable iff (rst)
        $onehot0(laneValid) && ((|laneValid) == inValid));

endmodule

`default_nettype wire

//--- verilog/resultArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module resultArbiter import intOpPkg::*; import uopPkg::*; (
    input  wire                 clk,
    input  wire                 rst,
    input  IntResult            resOut [NumLanes],
    input  wire  [NumLanes-1:0] resValid,
    output logic [NumLanes-1:0] resReady,
    output IntResult            outRes,
    output logic                outValid,
    input  wire                 outReady
);

    Lane_t lastGrant;
    Lane_t grant;
    Lane_t stallLane;
    logic grantValid;
    logic stalled;

    always_comb begin
        int idx;
        grant = lastGrant;
        grantValid = 1'b0;
        // walk backwards so the lane right after lastGrant ends up on top
        for (int k = NumLanes; k >= 1; k--) begin
            idx = (int'(lastGrant) + k) % NumLanes;
            if (resValid[idx]) begin
                grant = Lane_t'(idx);
                grantValid = 1'b1;
            end
        end
        if (stalled && resValid[stallLane]) begin
            grant = stallLane; // keep offering the lane that was refused last cycle
            grantValid = 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < NumLanes; i++) begin
            resReady[i] = outReady && grantValid && (grant == Lane_t'(i));
        end
    end

    assign outValid = grantValid;
    assign outRes = resOut[grant];

    always_ff @(posedge clk) begin
        if (rst) begin
            lastGrant <= Lane_t'(NumLanes - 1); // first search starts at lane 0
            stalled <= 1'b0;
        end else begin
            stalled <= outValid && !outReady;
            if (outValid && outReady) begin
                lastGrant <= grant;
            end
        end
    end

    always_ff @(posedge clk) begin
        stallLane <= grant;
    end

endmodule

`default_nettype wire

//--- verilog/intCluster.sv
`timescale 1ns/1ps
`default_nettype none

module intCluster import intOpPkg::*; import uopPkg::*; (
    input  wire      clk,
    input  wire      rst,
    input  IntUop    inUop,
    input  wire      inValid,
    output logic     inReady,
    input  wire      invalidate,
    input  SqN_t     invalidateSqN,
    output IntResult outRes,
    output logic     outValid,
    input  wire      outReady
);

    IntUop laneUop [NumLanes];
    logic [NumLanes-1:0] laneValid;
    logic [NumLanes-1:0] laneReady;
    IntResult resOut [NumLanes];
    logic [NumLanes-1:0] resValid;
    logic [NumLanes-1:0] resReady;

    issueDispatch i_dispatch (
        .clk       (clk),
        .rst       (rst),
        .inUop     (inUop),
        .inValid   (inValid),
        .inReady   (inReady),
        .laneUop   (laneUop),
        .laneValid (laneValid),
        .laneReady (laneReady)
    );

    for (genvar i = 0; i < NumLanes; i++) begin : gLane
        intAlu i_alu (
            .clk           (clk),
            .rst           (rst),
            .laneUop       (laneUop[i]),
            .laneValid     (laneValid[i]),
            .laneReady     (laneReady[i]),
            .invalidate    (invalidate),
            .invalidateSqN (invalidateSqN),
            .resOut        (resOut[i]),
            .resValid      (resValid[i]),
            .resReady      (resReady[i])
        );
    end

    resultArbiter i_arbiter (
        .clk      (clk),
        .rst      (rst),
        .resOut   (resOut),
        .resValid (resValid),
        .resReady (resReady),
        .outRes   (outRes),
        .outValid (outValid),
        .outReady (outReady)
    );

endmodule

`default_nettype wire

//--- test/tbIntCluster.sv
`timescale 1ns/1ps
`default_nettype none

module tbIntCluster import intOpPkg::*; import uopPkg::*; ();

    localparam int ClkPeriod = 40;
    localparam int CyclesPerLine = 200;

    logic clk = 1'b0;
    logic rst;
    IntUop inUop;
    logic inValid;
    logic inReady;
    logic invalidate;
    SqN_t invalidateSqN;
    IntResult outRes;
    logic outValid;
    logic outReady = 1'b0;

    // scoreboard, one slot per sequence number
    string  expName [128];
    IntOp_t expOp [128];
    Word_t  expRes [128];
    logic   expMis [128];
    Word_t  expDst [128];
    bit     pending [128];
    bit     killed [128];
    bit     seen [128];
    int     remaining = 0;
    int     lineCount = 0;
    bit     linesCounted = 1'b0;
    bit     hold = 1'b0; // keeps outReady low so micro-ops pile up in the lanes
    bit     killPending = 1'b0;
    SqN_t   killSqN = '0;
    SqN_t   fillQ [$]; // micro-ops accepted since outReady was held low, oldest first
    bit     wasStalled = 1'b0;
    SqN_t   stalledSqN = '0;

    intCluster i_dut (
        .clk           (clk),
        .rst           (rst),
        .inUop         (inUop),
        .inValid       (inValid),
        .inReady       (inReady),
        .invalidate    (invalidate),
        .invalidateSqN (invalidateSqN),
        .outRes        (outRes),
        .outValid      (outValid),
        .outReady      (outReady)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    // the pointed-to lane holds the micro-op sent NumLanes accepts ago unless it was killed
    function automatic logic expectedInReady();
        int k;
        k = fillQ.size();
        if (k < NumLanes) begin
            return 1'b1;
        end
        return killed[fillQ[k - NumLanes]];
    endfunction

    task automatic abortRun();
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkValue(string name, string field, Word_t expected, Word_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s %s: expected %h, actual %h", name, field, expected, actual);
            abortRun();
        end
    endtask

    task automatic handleResult(IntResult r);
        int s;
        s = int'(r.sqN);
        if (killed[s]) begin
            $display("sqN %0d reached the output although it was invalidated", s);
            abortRun();
        end else if (seen[s]) begin
            $display("sqN %0d reached the output a second time", s);
            abortRun();
        end else if (!pending[s]) begin
            $display("a result arrived with the unknown sqN %0d", s);
            abortRun();
        end else begin
            if (!(expOp[s] >= OpBeq && expOp[s] <= OpBgeu)) begin // branches write no value
                checkValue(expName[s], "result", expRes[s], r.result);
            end
            checkValue(expName[s], "tagDst", Word_t'(s[5:0]), Word_t'(r.tagDst));
            checkValue(expName[s], "mispredict", Word_t'(expMis[s]), Word_t'(r.mispredict));
            if (expMis[s]) begin
                checkValue(expName[s], "dstPc", expDst[s], r.dstPc);
            end
            seen[s] = 1'b1;
            pending[s] = 1'b0;
            remaining--;
        end
    endtask

    task automatic applyUop(IntUop u);
        @(negedge clk);
        inUop <= u;
        inValid <= 1'b1;
        invalidate <= killPending; // kill lands in the first cycle this micro-op is offered
        invalidateSqN <= killSqN;
        killPending = 1'b0;
        #1;
        if (hold) begin
            checkValue("fill", "inReady", Word_t'(expectedInReady()), Word_t'(inReady));
        end
        while (!inReady) begin
            @(negedge clk);
            invalidate <= 1'b0;
            #1;
        end
        if (hold) begin
            fillQ.push_back(u.sqN);
        end
    endtask

    task automatic idleInputs();
        @(negedge clk);
        inValid <= 1'b0;
        invalidate <= 1'b0;
    endtask

    // output side: random ready, results sampled late in the cycle
    always @(negedge clk) begin
        outReady <= hold ? 1'b0 : ($urandom % 4 != 0);
        #(ClkPeriod / 2 - 5);
        if (!rst && wasStalled && !invalidate) begin // a refused result is offered again
            checkValue("stall", "outValid", 32'd1, Word_t'(outValid));
            checkValue("stall", "sqN", Word_t'(stalledSqN), Word_t'(outRes.sqN));
        end
        wasStalled = !rst && outValid && !outReady;
        stalledSqN = outRes.sqN;
        if (!rst && outValid && outReady) begin
            handleResult(outRes);
        end
    end

    initial begin
        wait (linesCounted);
        repeat (CyclesPerLine * lineCount) @(posedge clk);
        $display("timeout with %0d results still missing", remaining);
        abortRun();
    end

    initial begin
        int fd;
        int code;
        int n;
        int s;
        int c;
        int p;
        int sq;
        int mis;
        string kind;
        string name;
        string line;
        logic [5:0] op;
        Word_t a;
        Word_t b;
        Word_t imm;
        Word_t pc;
        Word_t res;
        Word_t dst;
        IntUop u;

        void'($urandom(23660));
        rst = 1'b1;
        inUop = '0;
        inValid = 1'b0;
        invalidate = 1'b0;
        invalidateSqN = '0;

        fd = $fopen("test/intCluster_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/intCluster_stim.txt");
            abortRun();
        end
        while ($fgets(line, fd) != 0) begin
            lineCount++;
        end
        $fclose(fd);
        linesCounted = 1'b1;
        fd = $fopen("test/intCluster_stim.txt", "r");

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;
        #1;
        checkValue("reset", "inReady", 32'd1, Word_t'(inReady));
        checkValue("reset", "outValid", 32'd0, Word_t'(outValid));

        while ($fscanf(fd, "%s", kind) == 1) begin
            if (kind == "U") begin
                code = $fscanf(fd, "%s %h %h %h %h %h %d %d %d %h %d %h",
                               name, op, a, b, imm, pc, c, p, sq, res, mis, dst);
                if (code != 12) begin
                    $display("a micro-op line in the stim file is malformed");
                    abortRun();
                end
                expName[sq] = name;
                expOp[sq] = IntOp_t'(op);
                expRes[sq] = res;
                expMis[sq] = mis[0];
                expDst[sq] = dst;
                if (!killed[sq]) begin
                    pending[sq] = 1'b1;
                    remaining++;
                end
                u.srcA = a;
                u.srcB = b;
                u.imm = imm;
                u.pc = pc;
                u.opcode = IntOp_t'(op);
                u.sqN = SqN_t'(sq);
                u.tagDst = Tag_t'(sq);
                u.compressed = c[0];
                u.predTaken = p[0];
                applyUop(u);
            end else if (kind == "K") begin
                code = $fscanf(fd, "%d %d", sq, n);
                killPending = 1'b1;
                killSqN = SqN_t'(sq);
                for (int i = 0; i < n; i++) begin
                    code = $fscanf(fd, "%d", s);
                    killed[s] = 1'b1;
                    if (pending[s]) begin
                        pending[s] = 1'b0;
                        remaining--;
                    end
                end
            end else if (kind == "B") begin
                code = $fscanf(fd, "%d", n);
                idleInputs();
                #1;
                if (hold) begin
                    checkValue("fill", "inReady", Word_t'(expectedInReady()), Word_t'(inReady));
                end
                if (n != 0) begin
                    wait (remaining == 0); // every lane is empty once all results drained
                    fillQ.delete();
                end
                hold = (n != 0);
            end else begin
                void'($fgets(line, fd)); // comment line
            end
        end
        $fclose(fd);

        idleInputs();
        wait (remaining == 0);
        repeat (20) @(negedge clk); // room for a late duplicate or killed result to show up
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/intCluster_stim.txt
# U name op srcA srcB imm pc compressed predTaken sqN result mispredict dstPc (op and words in hex)
# K invSqN count killedSqNs... / B 1 holds outReady low once idle, B 0 releases it
U add_wrap 00 00000005 fffffffd 00000000 00000000 0 0 1 00000002 0 00000000
U xor_mix 04 f0f0f0f0 ff00ff00 00000000 00000000 0 0 2 0ff00ff0 0 00000000
U sll_mask 05 00000001 00000021 00000000 00000000 0 0 3 00000002 0 00000000
U sra_neg 07 80000010 00000004 00000000 00000000 0 0 4 f8000001 0 00000000
U sra_mask 07 fffffff0 00000022 00000000 00000000 0 0 5 fffffffc 0 00000000
U slt_neg 08 ffffffff 00000001 00000000 00000000 0 0 6 00000001 0 00000000
U auipc 0b 00000000 00000000 00002000 00001000 0 0 7 00003000 0 00000000
U andn 0c ffff00ff 0000f0f0 00000000 00000000 0 0 8 ffff000f 0 00000000
U min_neg 0f fffffff0 00000005 00000000 00000000 0 0 9 fffffff0 0 00000000
U maxu 12 fffffff0 00000005 00000000 00000000 0 0 10 fffffff0 0 00000000
U sh3add 15 00000003 00000010 00000000 00000000 0 0 11 00000028 0 00000000
U clz_zero 16 00000000 00000000 00000000 00000000 0 0 12 00000020 0 00000000
U ctz_zero 17 00000000 00000000 00000000 00000000 0 0 13 00000020 0 00000000
U ctz_bit8 17 00000100 00000000 00000000 00000000 0 0 14 00000008 0 00000000
U cpop 18 f000000f 00000000 00000000 00000000 0 0 15 00000008 0 00000000
U rev8 19 12345678 00000000 00000000 00000000 0 0 16 78563412 0 00000000
U orc_b 1a 00800100 00000000 00000000 00000000 0 0 17 00ffff00 0 00000000
U sext_b 1b 00000080 00000000 00000000 00000000 0 0 18 ffffff80 0 00000000
U sext_h 1c 12348001 00000000 00000000 00000000 0 0 19 ffff8001 0 00000000
U beq_tn 1d 00000005 00000005 00000010 00002000 0 0 20 00000000 1 00002010
U bne_nt_c 1e 00000005 00000005 00000010 00002000 1 1 21 00000000 1 00002002
U blt_tt 1f ffffffff 00000001 00001ff0 00002000 0 1 22 00000000 0 00000000
U bge_nn 20 ffffffff 00000001 00001ff0 00002000 0 0 23 00000000 0 00000000
U bltu_tn_c 21 00000001 ffffffff 00001ff0 00002000 1 0 24 00000000 1 00001ff0
U bgeu_nt 22 00000001 ffffffff 00000010 00002000 0 1 25 00000000 1 00002004
U jal_n_c 23 00000000 00000000 00000100 00003000 1 0 26 00003002 1 00003100
U jal_t 23 00000000 00000000 00000100 00003000 0 1 27 00003004 0 00000000
B 1
U kill_old 00 00000001 00000001 00000000 00000000 0 0 40 00000002 0 00000000
U kill_held 00 00000002 00000002 00000000 00000000 0 0 41 00000004 0 00000000
K 40 2 41 42
U kill_in 00 00000003 00000003 00000000 00000000 0 0 42 00000006 0 00000000
B 0
U after_kill 00 00000004 00000004 00000000 00000000 0 0 43 00000008 0 00000000

//--- vlog.f
verilog/intOpPkg.sv
verilog/uopPkg.sv
verilog/bitCount.sv
verilog/intAlu.sv
verilog/issueDispatch.sv
verilog/resultArbiter.sv
verilog/intCluster.sv
test/tbIntCluster.sv

//--- run.sh
#!/usr/bin/env bash
# builds the cluster testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tbIntCluster -f vlog.f -o simIntCluster

./obj_dir/simIntCluster
